// ==== apb_decode.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB access decode
// Classifies by window and direction, captures one access
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module apb_decode #(
  parameter logic [31:0] REG_BASE   = 32'h1000_1000,
  parameter logic [31:0] FLASH_BASE = 32'h3000_0000
) (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  logic [31:0]             paddr_i,
  input  logic [31:0]             pwdata_i,
  input  logic [3:0]              pstrb_i,
  input  logic                    done_i,
  output spi_flash_pkg::apb_req_t req_o,
  output logic                    req_valid_o
);
  import spi_flash_pkg::*;

  logic         in_reg;
  logic         in_flash;
  logic         capture;
  access_kind_e kind;
  apb_req_t     req_q;
  logic         req_valid_q;
  logic         busy_q;
  logic         done_q;
  logic         in_flight_q;

  // 4 KiB register window, 256 MiB flash window
  assign in_reg   = (paddr_i[31:12] == REG_BASE[31:12]);
  assign in_flash = (paddr_i[31:28] == FLASH_BASE[31:28]);
  assign capture  = psel_i && penable_i && !busy_q;

  always_comb begin
    if (in_reg) begin
      kind = pwrite_i ? ACC_REG_WRITE : ACC_REG_READ;
    end else if (in_flash && !pwrite_i) begin
      kind = ACC_FLASH_READ;
    end else begin
      kind = ACC_ERROR;
    end
  end

  always_ff @(posedge clock) begin
    if (capture) begin
      req_q.kind  <= kind;
      req_q.addr  <= paddr_i;
      req_q.wdata <= pwdata_i;
      req_q.strb  <= pstrb_i;
    end
  end

  // Busy is held through the pready cycle so the same access is not taken twice
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      req_valid_q <= 1'b0;
      busy_q      <= 1'b0;
      done_q      <= 1'b0;
      in_flight_q <= 1'b0;
    end else begin
      req_valid_q <= capture;
      done_q      <= done_i;
      if (capture) begin
        busy_q <= 1'b1;
      end else if (done_q) begin
        busy_q <= 1'b0;
      end
      // Request handed on and its done not yet seen
      if (done_i) begin
        in_flight_q <= 1'b0;
      end else if (req_valid_q) begin
        in_flight_q <= 1'b1;
      end
    end
  end

  assign req_o       = req_q;
  assign req_valid_o = req_valid_q;

  a_no_capture_busy : assert property (
    @(posedge clock) disable iff (reset) req_valid_o |-> !in_flight_q
  ) else $error("new request while previous access in flight");

endmodule

// ==== apb_result.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB response stage
// Read data, pready and pslverr
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module apb_result (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        done_i,
  input  spi_flash_pkg::access_kind_e done_src_i,
  input  logic [31:0]                 done_data_i,
  output logic                        pready_o,
  output logic [31:0]                 prdata_o,
  output logic                        pslverr_o
);
  import spi_flash_pkg::*;

  logic        pready_q;
  logic        pslverr_q;
  logic [31:0] prdata_q;
  logic        has_data;

  assign has_data = (done_src_i == ACC_REG_READ) || (done_src_i == ACC_FLASH_READ);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      pready_q  <= 1'b0;
      pslverr_q <= 1'b0;
    end else begin
      pready_q  <= done_i;
      pslverr_q <= done_i && done_src_i == ACC_ERROR;
    end
  end

  // Writes and errors return zero
  always_ff @(posedge clock) begin
    if (done_i) begin
      prdata_q <= has_data ? done_data_i : 32'd0;
    end
  end

  assign pready_o  = pready_q;
  assign prdata_o  = prdata_q;
  assign pslverr_o = pslverr_q;

  a_pready_pulse : assert property (
    @(posedge clock) disable iff (reset) pready_o |=> !pready_o
  ) else $error("pready held for more than one cycle");

endmodule

// ==== build.f ====
spi_flash_pkg.sv
apb_decode.sv
xip_sequencer.sv
spi_master.sv
apb_result.sv
spi_flash_top.sv
tb_flash_model.sv
tb_spi_flash.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_spi_flash -Mdir obj_dir -o sim_spi_flash -f build.f; then
  echo "Build failed"
  exit 1
fi

out=$(./obj_dir/sim_spi_flash 2>&1)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qF 'All tests passed!'; then
  exit 0
fi
exit 1

// ==== spi_flash_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI flash bridge shared types
// Register map, request structs and SPI control word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package spi_flash_pkg;

  // SPI master register offsets
  localparam logic [4:0] REG_RX0_TX0 = 5'h00;
  localparam logic [4:0] REG_RX1_TX1 = 5'h04;
  localparam logic [4:0] REG_CTRL    = 5'h10;
  localparam logic [4:0] REG_DIVIDER = 5'h14;
  localparam logic [4:0] REG_SS      = 5'h18;

  // Standard serial NOR read
  localparam logic [7:0] FLASH_CMD_READ = 8'h03;

  typedef enum logic [1:0] {
    ACC_REG_WRITE,
    ACC_REG_READ,
    ACC_FLASH_READ,
    ACC_ERROR
  } access_kind_e;

  typedef struct packed {
    access_kind_e kind;
    logic [31:0]  addr;
    logic [31:0]  wdata;
    logic [3:0]   strb;
  } apb_req_t;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [4:0]  offset;
    logic [31:0] wdata;
  } spi_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] rdata;
  } spi_rsp_t;

  // Control register layout, char_len of 0 means 64 bits
  typedef struct packed {
    logic [17:0] rsvd_hi;
    logic        ass;
    logic [1:0]  rsvd_b;
    logic        tx_neg;
    logic        rsvd_a;
    logic        go;
    logic        rsvd_c;
    logic [6:0]  char_len;
  } spi_ctrl_fields_t;

  typedef union packed {
    logic [31:0]      raw;
    spi_ctrl_fields_t fields;
  } spi_ctrl_u;

endpackage

// ==== spi_flash_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB to SPI NOR flash bridge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module spi_flash_top #(
  parameter logic [31:0] REG_BASE      = 32'h1000_1000,
  parameter logic [31:0] FLASH_BASE    = 32'h3000_0000,
  parameter int          SS_NUM        = 8,
  parameter logic [31:0] FLASH_DIVIDER = 32'd4
) (
  input  logic              clock,
  input  logic              reset,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [31:0]       paddr_i,
  input  logic [31:0]       pwdata_i,
  input  logic [3:0]        pstrb_i,
  output logic              pready_o,
  output logic [31:0]       prdata_o,
  output logic              pslverr_o,
  output logic              spi_sck_o,
  output logic [SS_NUM-1:0] spi_ss_o,
  output logic              spi_mosi_o,
  input  logic              spi_miso_i
);
  import spi_flash_pkg::*;

  apb_req_t     dec_req;
  logic         dec_req_valid;
  spi_req_t     spi_req;
  spi_rsp_t     spi_rsp;
  logic         seq_done;
  access_kind_e seq_done_src;
  logic [31:0]  seq_done_data;

  apb_decode #(
    .REG_BASE   (REG_BASE),
    .FLASH_BASE (FLASH_BASE)
  ) u_decode (
    .clock       (clock),
    .reset       (reset),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .paddr_i     (paddr_i),
    .pwdata_i    (pwdata_i),
    .pstrb_i     (pstrb_i),
    .done_i      (seq_done),
    .req_o       (dec_req),
    .req_valid_o (dec_req_valid)
  );

  xip_sequencer #(
    .FLASH_BASE    (FLASH_BASE),
    .FLASH_DIVIDER (FLASH_DIVIDER)
  ) u_sequencer (
    .clock       (clock),
    .reset       (reset),
    .req_i       (dec_req),
    .req_valid_i (dec_req_valid),
    .spi_req_o   (spi_req),
    .spi_rsp_i   (spi_rsp),
    .done_o      (seq_done),
    .done_src_o  (seq_done_src),
    .done_data_o (seq_done_data)
  );

  spi_master #(
    .SS_NUM (SS_NUM)
  ) u_spi (
    .clock      (clock),
    .reset      (reset),
    .spi_req_i  (spi_req),
    .spi_rsp_o  (spi_rsp),
    .spi_sck_o  (spi_sck_o),
    .spi_ss_o   (spi_ss_o),
    .spi_mosi_o (spi_mosi_o),
    .spi_miso_i (spi_miso_i)
  );

  apb_result u_result (
    .clock       (clock),
    .reset       (reset),
    .done_i      (seq_done),
    .done_src_i  (seq_done_src),
    .done_data_i (seq_done_data),
    .pready_o    (pready_o),
    .prdata_o    (prdata_o),
    .pslverr_o   (pslverr_o)
  );

endmodule

// ==== spi_master.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI master, mode 0, MSB first
// Register file and 64-bit shift engine with slave selects
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module spi_master #(
  parameter int SS_NUM = 8
) (
  input  logic                    clock,
  input  logic                    reset,
  input  spi_flash_pkg::spi_req_t spi_req_i,
  output spi_flash_pkg::spi_rsp_t spi_rsp_o,
  output logic                    spi_sck_o,
  output logic [SS_NUM-1:0]       spi_ss_o,
  output logic                    spi_mosi_o,
  input  logic                    spi_miso_i
);
  import spi_flash_pkg::*;

  spi_ctrl_u          ctrl_q;
  spi_ctrl_u          ctrl_wr;
  logic [15:0]        divider_q;
  logic [SS_NUM-1:0]  ss_q;
  logic [63:0]        shift_q;
  logic [31:0]        rdata_q;
  logic               ack_q;
  logic               wr;
  logic               rd;
  logic               start;
  logic [6:0]         start_len;
  logic [5:0]         start_idx;
  logic [15:0]        div_cnt_q;
  logic [6:0]         bit_cnt_q;
  logic [6:0]         bit_cnt_m1;
  logic [5:0]         bit_idx;
  logic [5:0]         nxt_idx;
  logic               sck_q;
  logic               mosi_q;
  logic               engine_on;
  logic               tick;
  logic               rise;
  logic               last_bit;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bus side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign wr = spi_req_i.valid && spi_req_i.write && !ack_q;
  assign rd = spi_req_i.valid && !spi_req_i.write && !ack_q;
  assign ctrl_wr.raw = spi_req_i.wdata;
  assign start = wr && spi_req_i.offset == REG_CTRL && ctrl_wr.fields.go;
  assign start_len = (ctrl_wr.fields.char_len == 7'd0) ? 7'd64 : ctrl_wr.fields.char_len;
  assign start_idx = 6'(start_len - 7'd1);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      ack_q     <= 1'b0;
      ctrl_q    <= '0;
      divider_q <= '0;
      ss_q      <= '0;
    end else begin
      ack_q <= spi_req_i.valid && !ack_q;
      if (wr) begin
        case (spi_req_i.offset)
          REG_CTRL:    ctrl_q.raw <= spi_req_i.wdata;
          REG_DIVIDER: divider_q  <= spi_req_i.wdata[15:0];
          REG_SS:      ss_q       <= spi_req_i.wdata[SS_NUM-1:0];
          default:     ;
        endcase
      end
      // Go drops with the last sampled bit
      if (last_bit) begin
        ctrl_q.fields.go <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rd) begin
      case (spi_req_i.offset)
        REG_RX0_TX0: rdata_q <= shift_q[31:0];
        REG_RX1_TX1: rdata_q <= shift_q[63:32];
        REG_CTRL:    rdata_q <= ctrl_q.raw;
        REG_DIVIDER: rdata_q <= 32'(divider_q);
        REG_SS:      rdata_q <= 32'(ss_q);
        default:     rdata_q <= '0;
      endcase
    end
  end

  // Received bits land where the sent bit was
  always_ff @(posedge clock) begin
    if (wr && spi_req_i.offset == REG_RX0_TX0) begin
      shift_q[31:0] <= spi_req_i.wdata;
    end else if (wr && spi_req_i.offset == REG_RX1_TX1) begin
      shift_q[63:32] <= spi_req_i.wdata;
    end else if (rise) begin
      shift_q[bit_idx] <= spi_miso_i;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Shift engine
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Keeps running after go drops until sck is back low
  assign engine_on  = ctrl_q.fields.go || sck_q;
  assign tick       = engine_on && div_cnt_q == 16'd0;
  assign rise       = tick && !sck_q;
  assign last_bit   = rise && bit_cnt_q == 7'd1;
  assign bit_cnt_m1 = bit_cnt_q - 7'd1;
  assign bit_idx    = bit_cnt_m1[5:0];
  assign nxt_idx    = bit_idx - 6'd1;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      sck_q     <= 1'b0;
      mosi_q    <= 1'b0;
      div_cnt_q <= '0;
      bit_cnt_q <= '0;
    end else if (start) begin
      sck_q     <= 1'b0;
      div_cnt_q <= divider_q;
      bit_cnt_q <= start_len;
      mosi_q    <= shift_q[start_idx];
    end else if (engine_on) begin
      if (div_cnt_q != 16'd0) begin
        div_cnt_q <= div_cnt_q - 16'd1;
      end else begin
        div_cnt_q <= divider_q;
        sck_q     <= ~sck_q;
        if (rise) begin
          bit_cnt_q <= bit_cnt_m1;
          if (!ctrl_q.fields.tx_neg && bit_cnt_q > 7'd1) begin
            mosi_q <= shift_q[nxt_idx];
          end
        end else if (ctrl_q.fields.tx_neg && ctrl_q.fields.go) begin
          mosi_q <= shift_q[bit_idx];
        end
      end
    end
  end

  // Automatic select only drives ss during a transfer
  assign spi_ss_o = ~(ss_q & {SS_NUM{!ctrl_q.fields.ass || ctrl_q.fields.go}});
  assign spi_sck_o  = sck_q;
  assign spi_mosi_o = mosi_q;
  assign spi_rsp_o.ack   = ack_q;
  assign spi_rsp_o.rdata = rdata_q;

  a_no_tx_write_busy : assert property (
    @(posedge clock) disable iff (reset)
    wr && (spi_req_i.offset == REG_RX0_TX0 || spi_req_i.offset == REG_RX1_TX1)
      |-> !ctrl_q.fields.go
  ) else $error("shift register written during transfer");

endmodule

// ==== tb_flash_model.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Behavioral SPI NOR flash, mode 0
// Answers the 0x03 read command
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_flash_model (
  input  logic       spi_sck_i,
  input  logic       spi_cs_n_i,
  input  logic       spi_mosi_i,
  output logic       spi_miso_o,
  output int         select_count_o,
  output logic [7:0] last_cmd_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0] cmd_addr;
  logic [23:0] rd_addr;
  logic [7:0]  cur_byte;
  int          bit_count;
  int          k;

  // Memory contents, a pure function of the byte address
  function automatic logic [7:0] byte_at(input logic [23:0] a);
    return a[7:0] ^ a[15:8] ^ 8'hA5;
  endfunction

  initial begin
    spi_miso_o     = 1'b0;
    select_count_o = 0;
    last_cmd_o     = 8'h00;
  end

  always @(negedge spi_cs_n_i) begin
    select_count_o = select_count_o + 1;
    bit_count      = 0;
    cmd_addr       = '0;
    rd_addr        = '0;
    while (!spi_cs_n_i) begin
      @(spi_sck_i or spi_cs_n_i);
      if (!spi_cs_n_i && spi_sck_i) begin
        // Command and address come in on the rising edge
        if (bit_count < 32) begin
          cmd_addr = {cmd_addr[30:0], spi_mosi_i};
        end
        bit_count = bit_count + 1;
        if (bit_count == 32) begin
          last_cmd_o = cmd_addr[31:24];
          rd_addr    = cmd_addr[23:0];
        end
      end else if (!spi_cs_n_i && !spi_sck_i && bit_count >= 32) begin
        // Data bits go out on the falling edge
        k          = bit_count - 32;
        cur_byte   = byte_at(rd_addr + 24'(k / 8));
        spi_miso_o = cur_byte[3'(7 - (k % 8))];
      end
    end
    spi_miso_o = 1'b0;
  end

endmodule

// ==== tb_spi_flash.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the APB to SPI flash bridge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_spi_flash;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] REG_BASE    = 32'h1000_1000;
  localparam logic [31:0] FLASH_BASE  = 32'h3000_0000;
  localparam int          CYCLE_LIMIT = 40000;

  logic        clock;
  logic        reset;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] paddr;
  logic [31:0] pwdata;
  logic [3:0]  pstrb;
  logic        pready;
  logic [31:0] prdata;
  logic        pslverr;
  logic        sck;
  logic [7:0]  ss;
  logic        mosi;
  logic        miso;
  int          select_count;
  logic [7:0]  last_cmd;
  int          cycles = 0;

  // Expected responses, oldest first
  string       exp_name_q[$];
  logic [31:0] exp_data_q[$];
  logic        exp_err_q[$];

  spi_flash_top #(
    .REG_BASE      (REG_BASE),
    .FLASH_BASE    (FLASH_BASE),
    .SS_NUM        (8),
    .FLASH_DIVIDER (32'd4)
  ) DUT (
    .clock      (clock),
    .reset      (reset),
    .psel_i     (psel),
    .penable_i  (penable),
    .pwrite_i   (pwrite),
    .paddr_i    (paddr),
    .pwdata_i   (pwdata),
    .pstrb_i    (pstrb),
    .pready_o   (pready),
    .prdata_o   (prdata),
    .pslverr_o  (pslverr),
    .spi_sck_o  (sck),
    .spi_ss_o   (ss),
    .spi_mosi_o (mosi),
    .spi_miso_i (miso)
  );

  tb_flash_model u_flash (
    .spi_sck_i      (sck),
    .spi_cs_n_i     (ss[0]),
    .spi_mosi_i     (mosi),
    .spi_miso_o     (miso),
    .select_count_o (select_count),
    .last_cmd_o     (last_cmd)
  );

  always #20 clock = ~clock;

  // Four bytes from addr, first byte in the top position
  function automatic logic [31:0] flash_word(input logic [23:0] addr);
    logic [31:0] w;
    logic [23:0] a;
    int          i;
    w = '0;
    for (i = 0; i < 4; i++) begin
      a = addr + 24'(i);
      w = {w[23:0], a[7:0] ^ a[15:8] ^ 8'hA5};
    end
    return w;
  endfunction

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("mismatch %s expected 0x%08h actual 0x%08h", name, expected, actual);
      $display("Test failures found");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic apb_access(input logic is_write, input logic [31:0] addr,
                            input logic [31:0] data);
    @(negedge clock);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = is_write;
    paddr   = addr;
    pwdata  = data;
    pstrb   = 4'hF;
    @(negedge clock);
    penable = 1'b1;
    @(negedge clock);
    while (!pready) @(negedge clock);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_read(input string name, input logic [31:0] addr,
                          input logic [31:0] exp_data, input logic exp_err);
    exp_name_q.push_back(name);
    exp_data_q.push_back(exp_data);
    exp_err_q.push_back(exp_err);
    apb_access(1'b0, addr, 32'd0);
  endtask

  // Writes and errors return zero data
  task automatic apb_write(input string name, input logic [31:0] addr,
                           input logic [31:0] data, input logic exp_err);
    exp_name_q.push_back(name);
    exp_data_q.push_back(32'd0);
    exp_err_q.push_back(exp_err);
    apb_access(1'b1, addr, data);
  endtask

  task automatic flash_read(input logic [23:0] off);
    apb_read($sformatf("flash read 0x%06h", off), FLASH_BASE + {8'd0, off},
             flash_word(off), 1'b0);
  endtask

  // Response checker
  always @(negedge clock) begin
    if (!reset && pready) begin
      if (exp_name_q.size() == 0) begin
        $display("pready seen with no access outstanding");
        $display("Test failures found");
        $fatal(1, "unexpected response");
      end else begin
        check(exp_name_q[0], exp_data_q[0], prdata);
        check({exp_name_q[0], " pslverr"}, {31'd0, exp_err_q[0]}, {31'd0, pslverr});
        void'(exp_name_q.pop_front());
        void'(exp_data_q.pop_front());
        void'(exp_err_q.pop_front());
      end
    end
  end

  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles", cycles);
      $display("Test failures found");
      $fatal(1, "run did not finish");
    end
  end

  initial begin
    logic [23:0] off;
    int          n;
    void'($urandom(32'hc9e1));
    clock   = 1'b0;
    reset   = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = 32'd0;
    pwdata  = 32'd0;
    pstrb   = 4'h0;
    repeat (2) @(negedge clock);
    reset = 1'b0;

    check("reset ss", 32'h0000_00FF, {24'd0, ss});
    check("reset sck", 32'd0, {31'd0, sck});
    check("reset pready", 32'd0, {31'd0, pready});

    apb_write("divider write", REG_BASE + 32'h14, 32'h0000_0009, 1'b0);
    apb_read("divider read", REG_BASE + 32'h14, 32'h0000_0009, 1'b0);

    flash_read(24'h000000);
    check("ss after read 0", 32'h0000_00FF, {24'd0, ss});
    check("read command", 32'h0000_0003, {24'd0, last_cmd});
    flash_read(24'h123456);
    check("ss after read 123456", 32'h0000_00FF, {24'd0, ss});
    flash_read(24'hFFFFFC);
    check("ss after read fffffc", 32'h0000_00FF, {24'd0, ss});

    n = select_count;
    apb_write("flash write", FLASH_BASE + 32'h40, 32'hDEAD_BEEF, 1'b1);
    check("flash write select", n, select_count);
    apb_read("outside read", 32'h2000_0000, 32'd0, 1'b1);
    apb_write("outside write", 32'h1000_2000, 32'h1234_5678, 1'b1);

    repeat (30) begin
      off = 24'($urandom) & 24'hFFFFFC;
      flash_read(off);
    end

    // go clear, tx_neg set, char_len 64
    apb_read("ctrl after flash", REG_BASE + 32'h10, (32'd1 << 10) | 32'd64, 1'b0);

    @(negedge clock);
    if (exp_name_q.size() != 0) begin
      $display("%0d responses never arrived", exp_name_q.size());
      $display("Test failures found");
      $fatal(1, "missing responses");
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

// ==== xip_sequencer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute-in-place sequencer
// Register pass-through or full flash read on the SPI master
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module xip_sequencer #(
  parameter logic [31:0] FLASH_BASE    = 32'h3000_0000,
  parameter logic [31:0] FLASH_DIVIDER = 32'd4
) (
  input  logic                        clock,
  input  logic                        reset,
  input  spi_flash_pkg::apb_req_t     req_i,
  input  logic                        req_valid_i,
  output spi_flash_pkg::spi_req_t     spi_req_o,
  input  spi_flash_pkg::spi_rsp_t     spi_rsp_i,
  output logic                        done_o,
  output spi_flash_pkg::access_kind_e done_src_o,
  output logic [31:0]                 done_data_o
);
  import spi_flash_pkg::*;

  typedef enum logic [3:0] {
    S_IDLE,
    S_REG,
    S_DIV,
    S_CTRL,
    S_TX1,
    S_TX0,
    S_SS_ON,
    S_GO,
    S_POLL,
    S_SS_OFF,
    S_RX0
  } step_e;

  step_e     state_q;
  step_e     next_step;
  spi_req_t  spi_req_q;
  spi_ctrl_u poll_ctrl;
  logic      skip_write;

  // One SPI master access per step
  function automatic spi_req_t build_req(input step_e step, input apb_req_t req);
    spi_ctrl_u   ctrl;
    logic [31:0] flash_off;
    spi_req_t    r;
    ctrl = '0;
    ctrl.fields.char_len = 7'd64;
    ctrl.fields.tx_neg = 1'b1;
    flash_off = req.addr - FLASH_BASE;
    r = '0;
    r.valid = 1'b1;
    r.write = 1'b1;
    case (step)
      S_REG: begin
        r.write  = (req.kind == ACC_REG_WRITE);
        r.offset = req.addr[4:0];
        r.wdata  = req.wdata;
      end
      S_DIV: begin
        r.offset = REG_DIVIDER;
        r.wdata  = FLASH_DIVIDER;
      end
      S_CTRL: begin
        r.offset = REG_CTRL;
        r.wdata  = ctrl.raw;
      end
      S_TX1: begin
        r.offset = REG_RX1_TX1;
        r.wdata  = {FLASH_CMD_READ, flash_off[23:0]};
      end
      S_TX0:    r.offset = REG_RX0_TX0;
      S_SS_ON: begin
        r.offset = REG_SS;
        r.wdata  = 32'd1;
      end
      S_GO: begin
        ctrl.fields.go = 1'b1;
        r.offset = REG_CTRL;
        r.wdata  = ctrl.raw;
      end
      S_POLL: begin
        r.write  = 1'b0;
        r.offset = REG_CTRL;
      end
      S_SS_OFF: r.offset = REG_SS;
      S_RX0: begin
        r.write  = 1'b0;
        r.offset = REG_RX0_TX0;
      end
      default:  r.valid = 1'b0;
    endcase
    return r;
  endfunction

  assign poll_ctrl.raw = spi_rsp_i.rdata;

  always_comb begin
    case (state_q)
      S_DIV:    next_step = S_CTRL;
      S_CTRL:   next_step = S_TX1;
      S_TX1:    next_step = S_TX0;
      S_TX0:    next_step = S_SS_ON;
      S_SS_ON:  next_step = S_GO;
      S_GO:     next_step = S_POLL;
      S_POLL:   next_step = poll_ctrl.fields.go ? S_POLL : S_SS_OFF;
      S_SS_OFF: next_step = S_RX0;
      default:  next_step = S_IDLE;
    endcase
  end

  // A register write with no byte strobes touches nothing
  assign skip_write = (req_i.kind == ACC_REG_WRITE) && (req_i.strb == 4'b0000);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state_q   <= S_IDLE;
      spi_req_q <= '0;
    end else if (state_q == S_IDLE) begin
      if (req_valid_i && req_i.kind == ACC_FLASH_READ) begin
        state_q   <= S_DIV;
        spi_req_q <= build_req(S_DIV, req_i);
      end else if (req_valid_i && req_i.kind != ACC_ERROR && !skip_write) begin
        state_q   <= S_REG;
        spi_req_q <= build_req(S_REG, req_i);
      end
    end else if (spi_req_q.valid) begin
      if (spi_rsp_i.ack) begin
        spi_req_q.valid <= 1'b0;
        state_q         <= next_step;
      end
    end else begin
      spi_req_q <= build_req(state_q, req_i);
    end
  end

  assign done_o = (state_q == S_IDLE && req_valid_i && (req_i.kind == ACC_ERROR || skip_write))
               || ((state_q == S_REG || state_q == S_RX0) && spi_rsp_i.ack);
  assign done_src_o  = req_i.kind;
  assign done_data_o = spi_rsp_i.rdata;
  assign spi_req_o   = spi_req_q;

  a_req_hold : assert property (
    @(posedge clock) disable iff (reset)
    spi_req_o.valid && !spi_rsp_i.ack |=> spi_req_o.valid && $stable(spi_req_o)
  ) else $error("SPI request changed before ack");

endmodule
